//--- Bender.yml
package:
  name: cpu

sources:
  - design/isaPkg.sv
  - design/ctrlPkg.sv
  - design/instructionDecoder.sv
  - design/registerFile.sv
  - design/alu.sv
  - design/programCounter.sv
  - design/controlUnit.sv
  - design/cpu.sv
  - target: test
    files:
      - verif/cpuTb.sv

//--- cpu.f
design/isaPkg.sv
design/ctrlPkg.sv
design/instructionDecoder.sv
design/registerFile.sv
design/alu.sv
design/programCounter.sv
design/controlUnit.sv
design/cpu.sv
verif/cpuTb.sv

//--- design/alu.sv
`default_nettype none

module alu (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         aluStart,
    input  isaPkg::aluFuncT              aluFunc,
    input  logic                         useImm,
    input  logic                         usePcOperand,
    input  logic [isaPkg::dataWidth-1:0] rs1Data,
    input  logic [isaPkg::dataWidth-1:0] rs2Data,
    input  logic [isaPkg::dataWidth-1:0] imm,
    input  logic [isaPkg::pcWidth-1:0]   pc,
    output logic                         aluDone,
    output logic [isaPkg::dataWidth-1:0] aluResult
);

    logic [isaPkg::dataWidth-1:0] opA;
    logic [isaPkg::dataWidth-1:0] opB;
    logic [isaPkg::dataWidth-1:0] simpleResult;
    logic [isaPkg::dataWidth-1:0] mcand;
    logic [isaPkg::dataWidth-1:0] mplier;
    logic [isaPkg::dataWidth-1:0] acc;
    logic [isaPkg::dataWidth-1:0] accNext;
    logic [4:0]                   stepCnt;
    logic                         mulBusy;
    logic                         mulLast;
    logic                         startMul;

    assign opA = usePcOperand ? {{(isaPkg::dataWidth - isaPkg::pcWidth){1'b0}}, pc} : rs1Data;
    assign opB = useImm ? imm : rs2Data;

    always_comb begin
        case (aluFunc)
            isaPkg::aluAdd: simpleResult = opA + opB;
            isaPkg::aluSub: simpleResult = opA - opB;
            isaPkg::aluAnd: simpleResult = opA & opB;
            isaPkg::aluOr:  simpleResult = opA | opB;
            isaPkg::aluXor: simpleResult = opA ^ opB;
            isaPkg::aluSlt: simpleResult = {31'b0, $signed(opA) < $signed(opB)};
            isaPkg::aluShl: simpleResult = opA << opB[4:0];
            isaPkg::aluShr: simpleResult = opA >> opB[4:0];
            default:        simpleResult = '0;
        endcase
    end

    assign startMul = aluStart && (aluFunc == isaPkg::aluMul);
    // Shift-and-add step, the first one runs on the start edge
    assign accNext = mplier[0] ? acc + mcand : acc;
    assign mulLast = mulBusy && (stepCnt == '0);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            aluDone <= 1'b0;
            mulBusy <= 1'b0;
            stepCnt <= '0;
        end else begin
            aluDone <= (aluStart && !startMul) || mulLast;
            if (startMul) begin
                mulBusy <= 1'b1;
                stepCnt <= 5'd30;
            end else if (mulBusy) begin
                mulBusy <= !mulLast;
                stepCnt <= stepCnt - 5'd1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (startMul) begin
            acc    <= opB[0] ? opA : '0;
            mcand  <= opA << 1;
            mplier <= opB >> 1;
        end else if (mulBusy) begin
            acc    <= accNext;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
        if (aluStart && !startMul) begin
            aluResult <= simpleResult;
        end else if (mulLast) begin
            aluResult <= accNext;
        end
    end

endmodule

`default_nettype wire

//--- design/controlUnit.sv
`default_nettype none

module controlUnit (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         instrLoaded,
    input  logic                         dataLoaded,
    input  logic                         dataStored,
    input  logic                         aluDone,
    input  logic                         isLoad,
    input  logic                         isStore,
    input  logic                         isJump,
    input  logic                         isBranch,
    input  logic                         writesReg,
    input  logic [isaPkg::dataWidth-1:0] rs1Data,
    output logic                         readInstr,
    output logic                         readData,
    output logic                         writeData,
    output logic                         decodeEn,
    output logic                         aluStart,
    output logic                         regWrite,
    output logic                         pcStep,
    output logic                         pcJump
);

    ctrlPkg::stateT state;
    ctrlPkg::stateT stateNext;
    logic           branchTaken;
    logic           takeJump;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state <= ctrlPkg::stFetch;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            ctrlPkg::stFetch: begin
                if (instrLoaded) begin
                    stateNext = ctrlPkg::stDecode;
                end
            end
            ctrlPkg::stDecode:  stateNext = ctrlPkg::stExecute;
            ctrlPkg::stExecute: stateNext = ctrlPkg::stWaitAlu;
            ctrlPkg::stWaitAlu: begin
                if (aluDone) begin
                    stateNext = (isLoad || isStore) ? ctrlPkg::stMemory : ctrlPkg::stWriteback;
                end
            end
            ctrlPkg::stMemory: begin
                // Load data is written directly on its pulse
                if ((isLoad && dataLoaded) || (isStore && dataStored)) begin
                    stateNext = ctrlPkg::stUpdatePc;
                end
            end
            ctrlPkg::stWriteback: stateNext = ctrlPkg::stUpdatePc;
            ctrlPkg::stUpdatePc:  stateNext = ctrlPkg::stFetch;
            default:              stateNext = ctrlPkg::stFetch;
        endcase
    end

    // Strobes stay up until the memory answers
    assign readInstr = (state == ctrlPkg::stFetch);
    assign readData  = (state == ctrlPkg::stMemory) && isLoad;
    assign writeData = (state == ctrlPkg::stMemory) && isStore;

    assign decodeEn = readInstr && instrLoaded;
    assign aluStart = (state == ctrlPkg::stExecute);

    assign regWrite = writesReg && ((state == ctrlPkg::stWriteback)
                                    || (readData && dataLoaded));

    // Zero check on rs1 for beqz
    assign branchTaken = isBranch && (rs1Data == '0);
    assign takeJump    = isJump || branchTaken;

    assign pcJump = (state == ctrlPkg::stUpdatePc) && takeJump;
    assign pcStep = (state == ctrlPkg::stUpdatePc) && !takeJump;

endmodule

`default_nettype wire

//--- design/cpu.sv
`default_nettype none

module cpu (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic [isaPkg::dataWidth-1:0] instruction,
    input  logic                         instrLoaded,
    input  logic [isaPkg::dataWidth-1:0] dataIn,
    input  logic                         dataLoaded,
    input  logic                         dataStored,
    output logic [isaPkg::dataWidth-1:0] instrAddr,
    output logic [isaPkg::dataWidth-1:0] dataAddr,
    output logic [isaPkg::dataWidth-1:0] dataOut,
    output logic                         readInstr,
    output logic                         readData,
    output logic                         writeData
);

    // Decoder outputs
    logic [isaPkg::regIdxWidth-1:0] rs1Idx;
    logic [isaPkg::regIdxWidth-1:0] rs2Idx;
    logic [isaPkg::regIdxWidth-1:0] rdIdx;
    logic [isaPkg::dataWidth-1:0]   imm;
    isaPkg::aluFuncT                aluFunc;
    logic                           useImm;
    logic                           usePcOperand;
    logic                           isLoad;
    logic                           isStore;
    logic                           isJump;
    logic                           isBranch;
    logic                           absJump;
    logic                           writesReg;
    ctrlPkg::wbSelT                 wbSel;

    // Sequencer controls
    logic decodeEn;
    logic aluStart;
    logic regWrite;
    logic pcStep;
    logic pcJump;

    // Datapath
    logic                         aluDone;
    logic [isaPkg::dataWidth-1:0] aluResult;
    logic [isaPkg::dataWidth-1:0] rs1Data;
    logic [isaPkg::dataWidth-1:0] rs2Data;
    logic [isaPkg::pcWidth-1:0]   pc;

    assign instrAddr = {{(isaPkg::dataWidth - isaPkg::pcWidth){1'b0}}, pc};
    assign dataAddr  = aluResult;
    assign dataOut   = rs2Data;

    instructionDecoder decoder (
        .Clock(Clock),
        .rstN(rstN),
        .decodeEn(decodeEn),
        .instruction(instruction),
        .rs1Idx(rs1Idx),
        .rs2Idx(rs2Idx),
        .rdIdx(rdIdx),
        .imm(imm),
        .aluFunc(aluFunc),
        .useImm(useImm),
        .usePcOperand(usePcOperand),
        .isLoad(isLoad),
        .isStore(isStore),
        .isJump(isJump),
        .isBranch(isBranch),
        // Link only steers the writeback source inside the decoder
        .isLink(),
        .absJump(absJump),
        .writesReg(writesReg),
        .wbSel(wbSel)
    );

    registerFile regFile (
        .Clock(Clock),
        .rstN(rstN),
        .rs1Idx(rs1Idx),
        .rs2Idx(rs2Idx),
        .rdIdx(rdIdx),
        .regWrite(regWrite),
        .wbSel(wbSel),
        .aluResult(aluResult),
        .loadData(dataIn),
        .pc(pc),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    alu aluUnit (
        .Clock(Clock),
        .rstN(rstN),
        .aluStart(aluStart),
        .aluFunc(aluFunc),
        .useImm(useImm),
        .usePcOperand(usePcOperand),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .imm(imm),
        .pc(pc),
        .aluDone(aluDone),
        .aluResult(aluResult)
    );

    programCounter pcReg (
        .Clock(Clock),
        .rstN(rstN),
        .pcStep(pcStep),
        .pcJump(pcJump),
        .absJump(absJump),
        .aluResult(aluResult),
        .rs1Data(rs1Data),
        .pc(pc)
    );

    controlUnit sequencer (
        .Clock(Clock),
        .rstN(rstN),
        .instrLoaded(instrLoaded),
        .dataLoaded(dataLoaded),
        .dataStored(dataStored),
        .aluDone(aluDone),
        .isLoad(isLoad),
        .isStore(isStore),
        .isJump(isJump),
        .isBranch(isBranch),
        .writesReg(writesReg),
        .rs1Data(rs1Data),
        .readInstr(readInstr),
        .readData(readData),
        .writeData(writeData),
        .decodeEn(decodeEn),
        .aluStart(aluStart),
        .regWrite(regWrite),
        .pcStep(pcStep),
        .pcJump(pcJump)
    );

endmodule

`default_nettype wire

//--- design/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // Sequencer states, one instruction walks through them in order
    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stExecute   = 3'd2,
        stWaitAlu   = 3'd3,
        stMemory    = 3'd4,
        stWriteback = 3'd5,
        stUpdatePc  = 3'd6
    } stateT;

    // Register write source
    typedef enum logic [1:0] {
        wbAlu  = 2'd0,
        wbLoad = 2'd1,
        wbPc   = 2'd2
    } wbSelT;

endpackage

`default_nettype wire

//--- design/instructionDecoder.sv
`default_nettype none

module instructionDecoder (
    input  logic                           Clock,
    input  logic                           rstN,
    input  logic                           decodeEn,
    input  logic [isaPkg::dataWidth-1:0]   instruction,
    output logic [isaPkg::regIdxWidth-1:0] rs1Idx,
    output logic [isaPkg::regIdxWidth-1:0] rs2Idx,
    output logic [isaPkg::regIdxWidth-1:0] rdIdx,
    output logic [isaPkg::dataWidth-1:0]   imm,
    output isaPkg::aluFuncT                aluFunc,
    output logic                           useImm,
    output logic                           usePcOperand,
    output logic                           isLoad,
    output logic                           isStore,
    output logic                           isJump,
    output logic                           isBranch,
    output logic                           isLink,
    output logic                           absJump,
    output logic                           writesReg,
    output ctrlPkg::wbSelT                 wbSel
);

    logic [isaPkg::dataWidth-1:0] instrQ;
    isaPkg::opcodeT               opcode;
    logic [isaPkg::dataWidth-1:0] smallImm;
    logic [isaPkg::dataWidth-1:0] largeImm;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            instrQ <= '0;
        end else if (decodeEn) begin
            instrQ <= instruction;
        end
    end

    assign opcode = isaPkg::opcodeT'(instrQ[31:26]);
    assign rdIdx  = instrQ[25:20];
    assign rs1Idx = instrQ[19:14];
    assign rs2Idx = instrQ[13:8];

    assign smallImm = {{18{instrQ[13]}}, instrQ[13:0]};
    assign largeImm = {{6{instrQ[25]}}, instrQ[25:0]};

    always_comb begin
        imm          = smallImm;
        aluFunc      = isaPkg::aluAdd;
        useImm       = 1'b0;
        usePcOperand = 1'b0;
        isLoad       = 1'b0;
        isStore      = 1'b0;
        isJump       = 1'b0;
        isBranch     = 1'b0;
        isLink       = 1'b0;
        absJump      = 1'b0;
        writesReg    = 1'b0;
        case (opcode)
            isaPkg::opAlu: begin
                aluFunc   = isaPkg::aluFuncT'(instrQ[5:0]);
                writesReg = 1'b1;
            end
            isaPkg::opAluImm: begin
                aluFunc   = isaPkg::aluFuncT'(instrQ[5:0]);
                useImm    = 1'b1;
                writesReg = 1'b1;
            end
            isaPkg::opLoad: begin
                useImm    = 1'b1;
                isLoad    = 1'b1;
                writesReg = 1'b1;
            end
            isaPkg::opStore: begin
                useImm  = 1'b1;
                isStore = 1'b1;
            end
            isaPkg::opJump: begin
                imm          = largeImm;
                useImm       = 1'b1;
                usePcOperand = 1'b1;
                isJump       = 1'b1;
            end
            isaPkg::opJumpReg: begin
                isJump  = 1'b1;
                absJump = 1'b1;
            end
            isaPkg::opJal: begin
                imm          = largeImm;
                useImm       = 1'b1;
                usePcOperand = 1'b1;
                isJump       = 1'b1;
                isLink       = 1'b1;
                writesReg    = 1'b1;
            end
            isaPkg::opBeqz: begin
                // Target is PC plus small immediate, condition checked later
                useImm       = 1'b1;
                usePcOperand = 1'b1;
                isBranch     = 1'b1;
            end
            default: begin
                // Unknown opcode falls through as a no-op
            end
        endcase
    end

    // Link has priority, it writes the current PC
    assign wbSel = isLink ? ctrlPkg::wbPc : (isLoad ? ctrlPkg::wbLoad : ctrlPkg::wbAlu);

endmodule

`default_nettype wire

//--- design/isaPkg.sv
`default_nettype none

package isaPkg;

    // Datapath widths
    localparam int dataWidth = 32;
    localparam int pcWidth = 26;
    localparam int regIdxWidth = 6;

    // Opcode field, bits 31..26
    typedef enum logic [5:0] {
        opAlu     = 6'h00,
        opAluImm  = 6'h01,
        opLoad    = 6'h02,
        opStore   = 6'h03,
        opJump    = 6'h04,
        opJumpReg = 6'h05,
        opJal     = 6'h06,
        opBeqz    = 6'h07
    } opcodeT;

    // Funct field, bits 5..0
    typedef enum logic [5:0] {
        aluAdd = 6'h00,
        aluSub = 6'h01,
        aluAnd = 6'h02,
        aluOr  = 6'h03,
        aluXor = 6'h04,
        // Signed compare
        aluSlt = 6'h05,
        aluShl = 6'h06,
        // Logical, amount from low 5 bits
        aluShr = 6'h07,
        aluMul = 6'h08
    } aluFuncT;

endpackage

`default_nettype wire

//--- design/programCounter.sv
`default_nettype none

module programCounter (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         pcStep,
    input  logic                         pcJump,
    input  logic                         absJump,
    input  logic [isaPkg::dataWidth-1:0] aluResult,
    input  logic [isaPkg::dataWidth-1:0] rs1Data,
    output logic [isaPkg::pcWidth-1:0]   pc
);

    logic [isaPkg::pcWidth-1:0] jumpTarget;

    // Register jump takes rs1, relative targets come from the ALU
    assign jumpTarget = absJump ? rs1Data[isaPkg::pcWidth-1:0]
                                : aluResult[isaPkg::pcWidth-1:0];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcJump) begin
            pc <= jumpTarget;
        end else if (pcStep) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/registerFile.sv
`default_nettype none

module registerFile (
    input  logic                           Clock,
    input  logic                           rstN,
    input  logic [isaPkg::regIdxWidth-1:0] rs1Idx,
    input  logic [isaPkg::regIdxWidth-1:0] rs2Idx,
    input  logic [isaPkg::regIdxWidth-1:0] rdIdx,
    input  logic                           regWrite,
    input  ctrlPkg::wbSelT                 wbSel,
    input  logic [isaPkg::dataWidth-1:0]   aluResult,
    input  logic [isaPkg::dataWidth-1:0]   loadData,
    input  logic [isaPkg::pcWidth-1:0]     pc,
    output logic [isaPkg::dataWidth-1:0]   rs1Data,
    output logic [isaPkg::dataWidth-1:0]   rs2Data
);

    localparam int numRegs = 2 ** isaPkg::regIdxWidth;

    logic [isaPkg::dataWidth-1:0] regs [numRegs];
    logic [isaPkg::dataWidth-1:0] writeData;

    // Writeback source
    always_comb begin
        case (wbSel)
            ctrlPkg::wbLoad: writeData = loadData;
            ctrlPkg::wbPc:   writeData = {{(isaPkg::dataWidth - isaPkg::pcWidth){1'b0}}, pc};
            default:         writeData = aluResult;
        endcase
    end

    // Register 0 is never written, so it reads as zero
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rdIdx != '0)) begin
            regs[rdIdx] <= writeData;
        end
    end

    assign rs1Data = regs[rs1Idx];
    assign rs2Data = regs[rs2Idx];

endmodule

`default_nettype wire

//--- verif/cpuTb.sv
`default_nettype none

module cpuTb;

    localparam int numInstr = 41;
    localparam int numRows = 21;
    // Multiply latency plus stall margin, three memory accesses per row
    localparam int cycleLimit = numRows * 40 * 3;

    logic        Clock = 1'b0;
    logic        rstN = 1'b0;
    logic [31:0] instruction = '0;
    logic        instrLoaded = 1'b0;
    logic [31:0] dataIn = '0;
    logic        dataLoaded = 1'b0;
    logic        dataStored = 1'b0;
    logic [31:0] instrAddr;
    logic [31:0] dataAddr;
    logic [31:0] dataOut;
    logic        readInstr;
    logic        readData;
    logic        writeData;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] progTable [numInstr];
    logic [31:0] dataInit [4] = '{32'h89AB_CDEF, 32'h1357_9BDF, 32'h2468_ACE0, 32'h0F1E_2D3C};

    // Columns: store flag, expected address (dataAddr or instrAddr), expected dataOut
    logic [64:0] expectTable [numRows] = '{
        {1'b1, 32'h0000_0310, 32'h0000_1A00},
        {1'b1, 32'h0000_0411, 32'h0000_1A80},
        {1'b1, 32'h0000_0512, 32'h0000_1A00},
        {1'b1, 32'h0000_0613, 32'h0000_0080},
        {1'b1, 32'h0000_0714, 32'h0000_1A43},
        {1'b1, 32'h0000_0815, 32'h0000_0001},
        {1'b1, 32'h0000_0916, 32'h0000_0000},
        {1'b1, 32'h0000_0A17, 32'h0000_3480},
        {1'b1, 32'h0000_0B18, 32'h7FFF_FFE0},
        {1'b1, 32'h0000_0C19, 32'hFFF9_6000},
        {1'b1, 32'h0000_0D1A, 32'h02B1_1000},
        {1'b1, 32'h0000_0E1B, 32'h1357_9BDF},
        {1'b1, 32'h0000_001C, 32'h0000_0000},
        {1'b0, 32'h0000_001C, 32'h0000_0000},
        {1'b0, 32'h0000_001D, 32'h0000_0000},
        {1'b0, 32'h0000_0020, 32'h0000_0000},
        {1'b0, 32'h0000_0024, 32'h0000_0000},
        {1'b0, 32'h0100_0027, 32'h0000_0000},
        {1'b0, 32'h0100_0028, 32'h0000_0000},
        {1'b0, 32'h0000_0025, 32'h0000_0000},
        {1'b1, 32'h0000_101D, 32'h0000_0024}
    };
    string testName [numRows] = '{
        "add", "sub", "and", "xor", "or immediate", "slt true", "slt false",
        "shift left", "shift right", "multiply negative", "multiply square",
        "load then store", "load into r0", "fetch after store", "beqz not taken",
        "beqz taken", "relative jump", "jal target", "step after jal",
        "register jump", "jal link"
    };

    logic [31:0] rngState = 32'hf47f;
    int          instrWait = -1;
    int          dataWait = -1;
    int          cycleCount = 0;
    int          errorCount = 0;
    int          passCount = 0;
    int          failCount = 0;
    logic        prevFetch = 1'b1;
    logic        prevWrite = 1'b0;

    cpu DUT (
        .Clock(Clock),
        .rstN(rstN),
        .instruction(instruction),
        .instrLoaded(instrLoaded),
        .dataIn(dataIn),
        .dataLoaded(dataLoaded),
        .dataStored(dataStored),
        .instrAddr(instrAddr),
        .dataAddr(dataAddr),
        .dataOut(dataOut),
        .readInstr(readInstr),
        .readData(readData),
        .writeData(writeData)
    );

    always #20 Clock = ~Clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] encReg(input isaPkg::opcodeT op, input logic [5:0] rd,
                                           input logic [5:0] rs1, input logic [5:0] rs2,
                                           input isaPkg::aluFuncT fn);
        return {op, rd, rs1, rs2, 2'b00, fn};
    endfunction

    // Small immediate shares bits with rs2 and funct
    function automatic logic [31:0] encImm(input isaPkg::opcodeT op, input logic [5:0] rd,
                                           input logic [5:0] rs1, input logic [13:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    function automatic logic [31:0] encLong(input isaPkg::opcodeT op, input logic [25:0] imm);
        return {op, imm};
    endfunction

    initial begin
        progTable = '{
            encImm(isaPkg::opAluImm, 6'd1, 6'd0, 14'h1A40),
            encImm(isaPkg::opAluImm, 6'd2, 6'd0, 14'h3FC0),
            encReg(isaPkg::opAlu, 6'd3, 6'd1, 6'd2, isaPkg::aluAdd),
            encReg(isaPkg::opAlu, 6'd4, 6'd1, 6'd2, isaPkg::aluSub),
            encReg(isaPkg::opAlu, 6'd5, 6'd3, 6'd4, isaPkg::aluAnd),
            encReg(isaPkg::opAlu, 6'd6, 6'd3, 6'd4, isaPkg::aluXor),
            encImm(isaPkg::opAluImm, 6'd7, 6'd3, 14'h0043),
            encReg(isaPkg::opAlu, 6'd8, 6'd2, 6'd1, isaPkg::aluSlt),
            encReg(isaPkg::opAlu, 6'd9, 6'd1, 6'd2, isaPkg::aluSlt),
            encReg(isaPkg::opAlu, 6'd10, 6'd1, 6'd8, isaPkg::aluShl),
            encReg(isaPkg::opAlu, 6'd11, 6'd2, 6'd8, isaPkg::aluShr),
            encReg(isaPkg::opAlu, 6'd12, 6'd4, 6'd2, isaPkg::aluMul),
            encReg(isaPkg::opAlu, 6'd13, 6'd1, 6'd1, isaPkg::aluMul),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0310),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0411),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0512),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0613),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0714),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0815),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0916),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0A17),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0B18),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0C19),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0D1A),
            encImm(isaPkg::opLoad, 6'd14, 6'd0, 14'h0005),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0E1B),
            encImm(isaPkg::opLoad, 6'd0, 6'd0, 14'h0006),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h001C),
            encImm(isaPkg::opBeqz, 6'd0, 6'd8, 14'h0005),
            encImm(isaPkg::opBeqz, 6'd0, 6'd9, 14'h0003),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0100),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0100),
            encLong(isaPkg::opJump, 26'h000_0004),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0100),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0100),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h0100),
            // jal with rd = r16 in the upper immediate bits
            encLong(isaPkg::opJal, 26'h100_0003),
            encImm(isaPkg::opStore, 6'd0, 6'd0, 14'h101D),
            encLong(isaPkg::opJump, 26'h000_0000),
            encReg(isaPkg::opAlu, 6'd17, 6'd16, 6'd8, isaPkg::aluAdd),
            encImm(isaPkg::opJumpReg, 6'd0, 6'd17, 14'h0000)
        };
        // Unused words hold undefined opcodes tagged with their address
        for (int i = 0; i < 64; i++) begin
            imem[i] = {6'h3F, 20'h0, 6'(i)};
            dmem[i] = 32'hD0D0_0000 | 32'(i);
        end
        for (int i = 0; i < numInstr; i++) begin
            imem[i] = progTable[i];
        end
        for (int i = 0; i < 4; i++) begin
            dmem[4 + i] = dataInit[i];
        end
    end

    // Memory models, each answer comes 0 to 3 cycles after the request
    always @(posedge Clock) begin
        if (instrLoaded) begin
            instrLoaded <= 1'b0;
            instrWait = -1;
        end else if (rstN && readInstr) begin
            if (instrWait < 0) begin
                rngState = xorshift(rngState);
                instrWait = int'(rngState[1:0]);
            end
            if (instrWait == 0) begin
                instruction <= imem[instrAddr[5:0]];
                instrLoaded <= 1'b1;
            end else begin
                instrWait = instrWait - 1;
            end
        end
        if (dataLoaded || dataStored) begin
            dataLoaded <= 1'b0;
            dataStored <= 1'b0;
            dataWait = -1;
        end else if (rstN && (readData || writeData)) begin
            if (dataWait < 0) begin
                rngState = xorshift(rngState);
                dataWait = int'(rngState[1:0]);
            end
            if (dataWait == 0 && readData) begin
                dataIn <= dmem[dataAddr[5:0]];
                dataLoaded <= 1'b1;
            end else if (dataWait == 0) begin
                dmem[dataAddr[5:0]] = dataOut;
                dataStored <= 1'b1;
            end else begin
                dataWait = dataWait - 1;
            end
        end
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the program did not finish within %0d cycles", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, want);
            errorCount = errorCount + 1;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        if (errorCount == errBefore) begin
            passCount = passCount + 1;
            $display("PASS %s", name);
        end else begin
            failCount = failCount + 1;
            $display("FAIL %s", name);
        end
    endtask

    // Waits for the next rising store or fetch strobe, sampled mid-cycle
    task automatic waitRequest(input logic wantStore);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge Clock);
            seen = wantStore ? (writeData && !prevWrite) : (readInstr && !prevFetch);
            prevWrite = writeData;
            prevFetch = readInstr;
        end
    endtask

    initial begin
        logic        isStore;
        logic [31:0] expAddr;
        logic [31:0] expData;
        int          errBefore;
        repeat (2) @(posedge Clock);
        rstN <= 1'b1;
        @(negedge Clock);
        errBefore = errorCount;
        checkValue("instrAddr", instrAddr, 32'h0);
        checkValue("readInstr", {31'b0, readInstr}, 32'h1);
        checkValue("readData", {31'b0, readData}, 32'h0);
        checkValue("writeData", {31'b0, writeData}, 32'h0);
        reportTest("reset state", errBefore);
        prevFetch = readInstr;
        prevWrite = writeData;
        for (int i = 0; i < numRows; i++) begin
            {isStore, expAddr, expData} = expectTable[i];
            waitRequest(isStore);
            errBefore = errorCount;
            if (isStore) begin
                checkValue("dataAddr", dataAddr, expAddr);
                checkValue("dataOut", dataOut, expData);
            end else begin
                checkValue("instrAddr", instrAddr, expAddr);
            end
            reportTest(testName[i], errBefore);
        end
        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
